/* include/mem_tile_defs.svh */
/*
  Width and depth settings of the memory tile.
  MEM_NUM_BANKS * SRAM_DATA_W must equal MEM_DATA_W, and AMO_WORD_W must equal SRAM_DATA_W
  so that one atomic lane maps onto one bank. MEM_ADDR_W must equal the sum of the address
  field widths that the package derives from these values.
*/
`ifndef MEM_TILE_DEFS_SVH
`define MEM_TILE_DEFS_SVH

// Tile word and its byte enables
`define MEM_DATA_W      64
`define MEM_BE_W        (`MEM_DATA_W / 8)

// One SRAM macro
`define SRAM_DATA_W     32
`define SRAM_NUM_WORDS  64

// Macro arrangement, banks side by side and rows in depth
`define MEM_NUM_BANKS   2
`define MEM_NUM_ROWS    2

// Byte address, 1 KiB in total
`define MEM_ADDR_W      10

`define MEM_ID_W        4

// Operand width of the atomic operations
`define AMO_WORD_W      32

`endif

/* src/mem_tile_pkg.sv */
/*
  Types shared by the memory tile and its checker.
  The address union only lines up while the derived field widths add up to MEM_ADDR_W.
*/
`include "mem_tile_defs.svh"

package mem_tile_pkg;

  // Address field widths
  localparam int unsigned ROW_SEL_W   = $clog2(`MEM_NUM_ROWS);
  localparam int unsigned SRAM_ADDR_W = $clog2(`SRAM_NUM_WORDS);
  localparam int unsigned BANK_SEL_W  = $clog2(`MEM_NUM_BANKS);
  localparam int unsigned BYTE_OFF_W  = $clog2(`SRAM_DATA_W / 8);

  typedef logic [`MEM_DATA_W-1:0] mem_data_t;
  typedef logic [`MEM_BE_W-1:0]   mem_be_t;
  typedef logic [`MEM_ID_W-1:0]   mem_id_t;

  typedef struct packed {
    logic [ROW_SEL_W-1:0]   row_sel;
    logic [SRAM_ADDR_W-1:0] sram_addr;
    logic [BANK_SEL_W-1:0]  bank_sel;
    logic [BYTE_OFF_W-1:0]  byte_off;
  } mem_addr_fields_t;

  // Byte address for the requester, fields for the tile
  typedef union packed {
    logic [`MEM_ADDR_W-1:0] raw;
    mem_addr_fields_t       f;
  } mem_addr_u;

  typedef enum logic [2:0] {
    AMO_NONE,
    AMO_SWAP,
    AMO_ADD,
    AMO_AND,
    AMO_OR,
    AMO_XOR
  } amo_op_e;

  typedef struct packed {
    mem_addr_u addr;
    logic      we;
    mem_data_t wdata;
    mem_be_t   be;
    amo_op_e   amo;
    mem_id_t   id;
  } mem_req_t;

  typedef struct packed {
    mem_data_t rdata;
    mem_id_t   id;
  } mem_rsp_t;

  // Command into the bank array, always accepted
  typedef struct packed {
    logic      req;
    logic      we;
    mem_addr_u addr;
    mem_data_t wdata;
    mem_be_t   be;
  } sram_req_t;

endpackage

/* src/sram_macro.sv */
/*
  Behavioral single-port SRAM, one cycle of read latency.
  No reset and no initial contents. Read data holds until the next read.
*/
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module sram_macro #(
  parameter int unsigned NUM_WORDS = `SRAM_NUM_WORDS,
  parameter int unsigned DATA_W    = `SRAM_DATA_W
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [DATA_W-1:0]            wdata_i,
  input  logic [DATA_W/8-1:0]          be_i,
  output logic [DATA_W-1:0]            rdata_o
);

  logic [DATA_W-1:0] mem_q [NUM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* src/mem_bank_array.sv */
/*
  Tile word storage, MEM_NUM_BANKS macros per word and MEM_NUM_ROWS rows in depth.
  Read data is valid exactly one cycle after a read command and is held until the next one.
  A macro sees no write when all its byte enables are off.
*/
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_bank_array
  import mem_tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  sram_req_t cmd_i,
  output mem_data_t rdata_o
);

  localparam int unsigned BANK_BE_W = `SRAM_DATA_W / 8;

  logic [ROW_SEL_W-1:0]   row_sel;
  logic [ROW_SEL_W-1:0]   row_sel_q;
  logic [SRAM_ADDR_W-1:0] sram_addr;

  logic [`MEM_NUM_BANKS-1:0][`SRAM_DATA_W-1:0] bank_wdata;
  logic [`MEM_NUM_BANKS-1:0][BANK_BE_W-1:0]    bank_be;
  logic [`MEM_NUM_BANKS-1:0][`SRAM_DATA_W-1:0] bank_rdata;

  logic [`MEM_NUM_ROWS-1:0][`MEM_NUM_BANKS-1:0] macro_req;
  logic [`MEM_NUM_ROWS-1:0][`MEM_NUM_BANKS-1:0][`SRAM_DATA_W-1:0] macro_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign row_sel   = cmd_i.addr.f.row_sel;
  assign sram_addr = cmd_i.addr.f.sram_addr;

  // Bank b takes the b-th 32-bit slice of the word
  assign bank_wdata = cmd_i.wdata;
  assign bank_be    = cmd_i.be;

  // Only the selected row, and on writes only banks with a byte enabled
  always_comb begin
    for (int r = 0; r < `MEM_NUM_ROWS; r++) begin
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
        macro_req[r][b] = cmd_i.req && (row_sel == ROW_SEL_W'(r)) &&
                          (!cmd_i.we || (|bank_be[b]));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Macros
  ////////////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MEM_NUM_ROWS; r++) begin : gen_rows
    for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : gen_banks
      sram_macro #(
        .NUM_WORDS(`SRAM_NUM_WORDS),
        .DATA_W   (`SRAM_DATA_W)
      ) i_macro (
        .clk_i  (clk_i),
        .req_i  (macro_req[r][b]),
        .we_i   (cmd_i.we),
        .addr_i (sram_addr),
        .wdata_i(bank_wdata[b]),
        .be_i   (bank_be[b]),
        .rdata_o(macro_rdata[r][b])
      );
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read data steering
  ////////////////////////////////////////////////////////////////////////////

  // Row of the last read, the macros only update their output on reads
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_sel_q <= '0;
    end else if (cmd_i.req && !cmd_i.we) begin
      row_sel_q <= row_sel;
    end
  end

  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      bank_rdata[b] = macro_rdata[row_sel_q][b];
    end
  end

  assign rdata_o = bank_rdata;

endmodule

/* src/mem_atop_unit.sv */
/*
  Request front end of the tile, one request in flight at a time.
  Plain requests respond one cycle after acceptance, atomic ones after two.
  The atomic operand sits in its own 32-bit lane of wdata, bank_sel picks the lane,
  and the request byte enables are ignored. Writes respond with zero data.
*/
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_atop_unit
  import mem_tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  mem_req_t  req_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output mem_rsp_t  rsp_o,
  output sram_req_t sram_cmd_o,
  input  mem_data_t sram_rdata_i
);

  localparam int unsigned AMO_LANES = `MEM_DATA_W / `AMO_WORD_W;
  localparam int unsigned LANE_BE_W = `AMO_WORD_W / 8;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_AMO_RD,
    ST_RSP
  } state_e;

  state_e    state_q;
  state_e    state_d;
  logic      req_accept;
  logic      rsp_done;
  logic      is_amo;
  logic      rd_pend_q;
  mem_req_t  req_q;
  mem_data_t rdata_q;

  logic [AMO_LANES-1:0][`AMO_WORD_W-1:0] old_lanes;
  logic [AMO_LANES-1:0][`AMO_WORD_W-1:0] op_lanes;
  logic [AMO_LANES-1:0][LANE_BE_W-1:0]   amo_be;
  logic [`AMO_WORD_W-1:0]                amo_old;
  logic [`AMO_WORD_W-1:0]                amo_operand;
  logic [`AMO_WORD_W-1:0]                amo_result;

  assign is_amo      = (req_i.amo != AMO_NONE);
  assign req_ready_o = (state_q == ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RSP);
  assign req_accept  = req_valid_i && req_ready_o;
  assign rsp_done    = rsp_valid_o && rsp_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (req_accept) begin
          state_d = is_amo ? ST_AMO_RD : ST_RSP;
        end
      end
      ST_AMO_RD: state_d = ST_RSP;
      ST_RSP: begin
        if (rsp_done) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      rd_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // SRAM read data shows up in the cycle after the read command
      rd_pend_q <= req_accept && (is_amo || !req_i.we);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      req_q <= req_i;
    end
    if (req_accept && !is_amo && req_i.we) begin
      rdata_q <= '0;
    end else if (rd_pend_q) begin
      rdata_q <= sram_rdata_i;
    end
  end

  // Bypass on the first cycle of a plain read response, register afterwards
  assign rsp_o.rdata = rd_pend_q ? sram_rdata_i : rdata_q;
  assign rsp_o.id    = req_q.id;

  ////////////////////////////////////////////////////////////////////////////
  // Atomic lane
  ////////////////////////////////////////////////////////////////////////////

  assign old_lanes   = sram_rdata_i;
  assign op_lanes    = req_q.wdata;
  assign amo_old     = old_lanes[req_q.addr.f.bank_sel];
  assign amo_operand = op_lanes[req_q.addr.f.bank_sel];

  always_comb begin
    unique case (req_q.amo)
      AMO_SWAP: amo_result = amo_operand;
      AMO_ADD:  amo_result = amo_old + amo_operand;
      AMO_AND:  amo_result = amo_old & amo_operand;
      AMO_OR:   amo_result = amo_old | amo_operand;
      AMO_XOR:  amo_result = amo_old ^ amo_operand;
      default:  amo_result = amo_old;
    endcase
  end

  always_comb begin
    amo_be                          = '0;
    amo_be[req_q.addr.f.bank_sel]   = '1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // SRAM command
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sram_cmd_o       = '0;
    sram_cmd_o.addr  = req_i.addr;
    sram_cmd_o.wdata = req_i.wdata;
    sram_cmd_o.be    = req_i.be;
    if (state_q == ST_IDLE) begin
      // Plain access, or the read half of an atomic
      sram_cmd_o.req = req_accept;
      sram_cmd_o.we  = req_i.we && !is_amo;
    end else if (state_q == ST_AMO_RD) begin
      sram_cmd_o.req   = 1'b1;
      sram_cmd_o.we    = 1'b1;
      sram_cmd_o.addr  = req_q.addr;
      sram_cmd_o.wdata = {AMO_LANES{amo_result}};
      sram_cmd_o.be    = amo_be;
    end
  end

endmodule

/* src/mem_tile.sv */
/*
  Memory tile top, atomic resolver in front of the SRAM bank array.
  Valid/ready on both channels, one request in flight. The response ID echoes the request ID.
*/
`timescale 1ns/1ps

module mem_tile
  import mem_tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Request channel
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mem_req_t req_i,
  // Response channel
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output mem_rsp_t rsp_o
);

  sram_req_t sram_cmd;
  mem_data_t sram_rdata;

  mem_atop_unit i_atop_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .sram_cmd_o  (sram_cmd),
    .sram_rdata_i(sram_rdata)
  );

  mem_bank_array i_bank_array (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .cmd_i  (sram_cmd),
    .rdata_o(sram_rdata)
  );

endmodule

/* tests/mem_tile_checker.sv */
/*
  Assertions bound into mem_tile, with a shadow copy of the tile contents.
  Every word must be written before it is read or used by an atomic.
  Failures bump err_cnt, which the testbench reads at the end.
*/
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_tile_checker
  import mem_tile_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     req_valid_i,
  input logic     req_ready_o,
  input mem_req_t req_i,
  input logic     rsp_valid_o,
  input logic     rsp_ready_i,
  input mem_rsp_t rsp_o
);

  localparam int WORDS = (1 << `MEM_ADDR_W) / `MEM_BE_W;
  localparam int AW    = `AMO_WORD_W;

  int        err_cnt = 0;
  logic      req_hs;
  logic      seen_req;
  mem_rsp_t  exp_rsp;
  mem_rsp_t  rsp_prev;
  mem_data_t shadow [WORDS];

  assign req_hs = req_valid_i && req_ready_o;

  function automatic logic [AW-1:0] amo_apply(input amo_op_e op, input logic [AW-1:0] old_v,
                                              input logic [AW-1:0] arg);
    case (op)
      AMO_SWAP: return arg;
      AMO_ADD:  return old_v + arg;
      AMO_AND:  return old_v & arg;
      AMO_OR:   return old_v | arg;
      AMO_XOR:  return old_v ^ arg;
      default:  return old_v;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_req <= 1'b0;
    end else if (req_hs) begin
      seen_req <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_prev <= rsp_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shadow memory and expected response
  ////////////////////////////////////////////////////////////////////////////

  // Word and 32-bit lane taken from the plain byte address
  always_ff @(posedge clk_i) begin : shadow_update
    int            idx;
    int            lane;
    logic [AW-1:0] old_lane;
    if (rst_n_i && req_hs) begin
      idx        = req_i.addr.raw / `MEM_BE_W;
      lane       = (req_i.addr.raw % `MEM_BE_W) / (AW / 8);
      exp_rsp.id <= req_i.id;
      if (req_i.amo != AMO_NONE) begin
        old_lane = shadow[idx][lane*AW +: AW];
        exp_rsp.rdata <= shadow[idx];
        shadow[idx][lane*AW +: AW] <= amo_apply(req_i.amo, old_lane, req_i.wdata[lane*AW +: AW]);
      end else if (req_i.we) begin
        exp_rsp.rdata <= '0;
        for (int b = 0; b < `MEM_BE_W; b++) begin
          if (req_i.be[b]) begin
            shadow[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        exp_rsp.rdata <= shadow[idx];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !seen_req |-> !rsp_valid_o && req_ready_o)
    else begin
      err_cnt++;
      $error("Error at %0t: rsp_valid_o/req_ready_o expected 0/1, got %b/%b", $time,
             $sampled(rsp_valid_o), $sampled(req_ready_o));
    end

  a_plain_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_hs && req_i.amo == AMO_NONE |=> rsp_valid_o)
    else begin
      err_cnt++;
      $error("Error at %0t: rsp_valid_o expected 1, got %b", $time, $sampled(rsp_valid_o));
    end

  a_amo_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_hs && req_i.amo != AMO_NONE |=> !rsp_valid_o ##1 rsp_valid_o)
    else begin
      err_cnt++;
      $error("Error at %0t: rsp_valid_o expected 0 then 1, got %b", $time,
             $sampled(rsp_valid_o));
    end

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && rsp_o == rsp_prev)
    else begin
      err_cnt++;
      $error("Error at %0t: rsp_valid_o/rsp_o expected 1/%h, got %b/%h", $time,
             $sampled(rsp_prev), $sampled(rsp_valid_o), $sampled(rsp_o));
    end

  a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> !req_ready_o)
    else begin
      err_cnt++;
      $error("Error at %0t: req_ready_o expected 0, got %b", $time, $sampled(req_ready_o));
    end

  a_rsp_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && rsp_ready_i |-> rsp_o.rdata == exp_rsp.rdata)
    else begin
      err_cnt++;
      $error("Error at %0t: rsp_o.rdata expected %h, got %h", $time,
             $sampled(exp_rsp.rdata), $sampled(rsp_o.rdata));
    end

  a_rsp_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && rsp_ready_i |-> rsp_o.id == exp_rsp.id)
    else begin
      err_cnt++;
      $error("Error at %0t: rsp_o.id expected %h, got %h", $time, $sampled(exp_rsp.id),
             $sampled(rsp_o.id));
    end

endmodule

bind mem_tile mem_tile_checker u_checker (.*);

/* tests/mem_tile_tb.sv */
/*
  Testbench of the memory tile. One request at a time, each waits for its response.
  The bound checker does all checking, this module reads its error count at the end.
*/
`timescale 1ns/1ps
`include "mem_tile_defs.svh"

module mem_tile_tb
  import mem_tile_pkg::*;
();

  localparam int ADDR_W       = `MEM_ADDR_W;
  localparam int WORDS        = (1 << `MEM_ADDR_W) / `MEM_BE_W;
  localparam int NUM_DIRECTED = 32;
  localparam int NUM_RANDOM   = 200;
  // Up to about four cycles per request with stalls, doubled
  localparam int TIMEOUT_CYCLES = 2 * 4 * (WORDS + NUM_DIRECTED + NUM_RANDOM);

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  logic     req_ready;
  mem_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  mem_rsp_t rsp;

  integer   seed;
  int       cycles;
  int       req_cnt;
  int       errors;
  int       kind;
  logic     stall_en;
  mem_id_t  id_cnt;
  logic [31:0] rnd;
  logic [ADDR_W-1:0] addr;
  mem_data_t wdata;
  mem_be_t   be;

  mem_tile dut0 (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_i      (req),
    .rsp_valid_o(rsp_valid),
    .rsp_ready_i(rsp_ready),
    .rsp_o      (rsp)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tile stopped answering", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // Starts and ends on a rising edge, after the response handshake
  task automatic do_req(input logic [ADDR_W-1:0] a, input logic w, input mem_data_t d,
                        input mem_be_t b, input amo_op_e op);
    logic done;
    req_valid    <= 1'b1;
    req.addr.raw <= a;
    req.we       <= w;
    req.wdata    <= d;
    req.be       <= b;
    req.amo      <= op;
    req.id       <= id_cnt;
    id_cnt = id_cnt + 1'b1;
    req_cnt++;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b0;
    done = 1'b0;
    while (!done) begin
      rsp_ready <= !stall_en || ($random(seed) % 4 != 0);
      @(negedge clk);
      done = rsp_valid && rsp_ready;
      @(posedge clk);
    end
  endtask

  initial begin
    seed      = 98;
    cycles    = 0;
    req_cnt   = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    stall_en  = 1'b0;
    id_cnt    = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    // Fill pattern from the whole word address
    for (int w = 0; w < WORDS; w++) begin
      do_req(ADDR_W'(w * `MEM_BE_W), 1'b1, mem_data_t'(w + 1) * 64'h9e37_79b9_7f4a_7c15,
             '1, AMO_NONE);
    end

    // Partial writes merged into a filled word
    do_req(10'h048, 1'b1, 64'h1122_3344_5566_7788, 8'h3c, AMO_NONE);
    do_req(10'h048, 1'b1, 64'hdead_beef_cafe_f00d, 8'h81, AMO_NONE);
    do_req(10'h048, 1'b0, '0, '0, AMO_NONE);

    // Same macro address in both rows
    do_req(10'h018, 1'b1, 64'h0123_4567_89ab_cdef, '1, AMO_NONE);
    do_req(10'h218, 1'b1, 64'hfedc_ba98_7654_3210, '1, AMO_NONE);
    do_req(10'h018, 1'b0, '0, '0, AMO_NONE);
    do_req(10'h218, 1'b0, '0, '0, AMO_NONE);

    for (int op = AMO_SWAP; op <= AMO_XOR; op++) begin
      for (int lane = 0; lane < `MEM_NUM_BANKS; lane++) begin
        do_req(ADDR_W'(10'h100 + lane * 4), 1'b0, {$random(seed), $random(seed)}, '0,
               amo_op_e'(op));
        do_req(10'h100, 1'b0, '0, '0, AMO_NONE);
      end
    end

    // Random mix with response stalls
    stall_en = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd   = $random(seed);
      kind  = rnd[2:0];
      rnd   = $random(seed);
      addr  = rnd[ADDR_W-1:0];
      be    = rnd[31:24];
      wdata = {$random(seed), $random(seed)};
      if (kind < 3) begin
        do_req(addr, 1'b0, '0, '0, AMO_NONE);
      end else if (kind < 6) begin
        do_req(addr, 1'b1, wdata, be, AMO_NONE);
      end else begin
        do_req(addr, 1'b0, wdata, '0, amo_op_e'(1 + rnd[20:10] % 5));
      end
    end
    stall_en = 1'b0;
    repeat (2) @(posedge clk);

    errors = dut0.u_checker.err_cnt;
    $display("Requests %0d, errors %0d", req_cnt, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
src/mem_tile_pkg.sv
src/sram_macro.sv
src/mem_bank_array.sv
src/mem_atop_unit.sv
src/mem_tile.sv
tests/mem_tile_checker.sv
tests/mem_tile_tb.sv
